/* Bender.yml */
package:
  name: uart_cmd_bridge

sources:
  - verilog/uart_frame_pkg.sv
  - verilog/uart_cmd_pkg.sv
  - verilog/uart_byte_if.sv
  - verilog/uart_tx_framer.sv
  - verilog/uart_rx_deframer.sv
  - verilog/uart_cmd_seq.sv
  - verilog/uart_cmd_bridge.sv
  - target: test
    files:
      - tests/tb_uart_cmd_bridge.sv

/* tests/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int CLKS_PER_BIT = 8;
  localparam int GAP_CYCLES   = 20;
  localparam int CLK_NS       = 40;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam int NUM_ENTRIES  = 8;
  localparam int WATCHDOG_NS  = 2 * (NUM_ENTRIES * 3 * uart_frame_pkg::FRAME_BITS * BIT_NS
                                     + NUM_ENTRIES * GAP_CYCLES * CLK_NS);

  typedef struct {
    uart_cmd_pkg::cmd_word_u cmd;
    uart_frame_pkg::byte_t   reply;
    logic                    bad_par;
    logic                    hold_next;
  } entry_t;

  logic clk, rst_n, cmd_vld, cmd_rdy, rx, tx, read_err, read_rdy;
  logic [15:0] cmd_in;
  logic [7:0]  read_data;

  entry_t stim[NUM_ENTRIES];
  int     n_filled, value_errors, other_errors, frames_seen, reply_base;
  logic   reply_req, reply_flip;
  uart_frame_pkg::byte_t reply_byte;
  uart_frame_pkg::byte_t tx_bytes[$], rd_bytes[$];
  logic                  tx_pars[$], tx_stops[$], rd_errs[$];

  uart_cmd_bridge #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES)
  ) u_uart_cmd_bridge (
    .clk (clk), .rst_n (rst_n), .cmd_in (cmd_in), .cmd_vld (cmd_vld), .cmd_rdy (cmd_rdy),
    .rx (rx), .tx (tx), .read_data (read_data), .read_err (read_err), .read_rdy (read_rdy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Odd parity counted bit by bit: an even number of ones needs a parity of one.
  function automatic logic expect_parity(input uart_frame_pkg::byte_t value);
    int ones;
    ones = 0;
    for (int k = 0; k < 8; k++)
      ones += value[k];
    return (ones % 2 == 0);
  endfunction

  task automatic check_byte(input string name, input uart_frame_pkg::byte_t exp,
                            input uart_frame_pkg::byte_t act);
    if (act !== exp)
    begin
      $display("** Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error at time %0t: %s expected %b, actual %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic add_entry(input logic wr, input logic [6:0] addr, input logic [7:0] data,
                           input logic [7:0] reply, input logic use_rand, input logic bad,
                           input logic hold);
    stim[n_filled].cmd.f.write = wr;
    stim[n_filled].cmd.f.addr  = addr;
    stim[n_filled].cmd.f.data  = data;
    stim[n_filled].reply       = use_rand ? uart_frame_pkg::byte_t'($urandom()) : reply;
    stim[n_filled].bad_par     = bad;
    stim[n_filled].hold_next   = hold;
    n_filled++;
  endtask

  // A frame is start, eight data bits LSB first, parity and stop.
  task automatic drive_frame(input uart_frame_pkg::byte_t value, input logic flip);
    logic [10:0] bits;
    bits = {1'b1, expect_parity(value) ^ flip, value, 1'b0};
    for (int k = 0; k < 11; k++)
    begin
      rx = bits[k];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  task automatic check_frame(input int k, input uart_frame_pkg::byte_t exp);
    check_byte("tx byte", exp, tx_bytes[k]);
    check_bit("tx parity", expect_parity(exp), tx_pars[k]);
    check_bit("tx stop", 1'b1, tx_stops[k]);
  endtask

  task automatic check_entry(input int i);
    int n_exp;
    n_exp = stim[i].cmd.f.write ? 2 : 1;
    if (tx_bytes.size() != n_exp)
    begin
      $display("Entry %0d put %0d frames on tx instead of %0d", i, tx_bytes.size(), n_exp);
      other_errors++;
    end
    else
    begin
      check_frame(0, {stim[i].cmd.f.write, stim[i].cmd.f.addr});
      if (n_exp == 2)
        check_frame(1, stim[i].cmd.f.data);
    end
    if (rd_bytes.size() != 2 - n_exp)
    begin
      $display("Entry %0d gave %0d read_rdy pulses instead of %0d", i, rd_bytes.size(), 2 - n_exp);
      other_errors++;
    end
    else if (n_exp == 1)
    begin
      check_byte("read_data", stim[i].reply, rd_bytes[0]);
      check_bit("read_err", stim[i].bad_par, rd_errs[0]);
    end
    tx_bytes.delete();
    tx_pars.delete();
    tx_stops.delete();
    rd_bytes.delete();
    rd_errs.delete();
  endtask

  // Samples land on falling clock edges, half a bit after each edge of the frame.
  initial
  begin : line_monitor
    uart_frame_pkg::byte_t value;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      #(BIT_NS / 2 + CLK_NS / 2);
      for (int k = 0; k < 8; k++)
      begin
        #(BIT_NS);
        value[k] = tx;
      end
      #(BIT_NS);
      tx_pars.push_back(tx);
      #(BIT_NS);
      tx_stops.push_back(tx);
      tx_bytes.push_back(value);
      frames_seen++;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n === 1'b1 && read_rdy === 1'b1)
    begin
      rd_bytes.push_back(read_data);
      rd_errs.push_back(read_err);
    end
  end

  initial
  begin : reply_driver
    forever
    begin
      wait (reply_req === 1'b1);
      wait (frames_seen > reply_base);
      repeat (3 * CLKS_PER_BIT) @(posedge clk);
      #1;
      drive_frame(reply_byte, reply_flip);
      reply_req = 1'b0;
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the table was finished", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    logic presented;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    reply_req = 1'b0;
    n_filled = 0;
    value_errors = 0;
    other_errors = 0;
    frames_seen = 0;
    reply_base = 0;
    void'($urandom(76));
    add_entry(1'b1, 7'h12, 8'hA5, 8'h00, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 7'h34, 8'h00, 8'h5A, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, 7'h01, 8'h00, 8'hC3, 1'b0, 1'b1, 1'b0);
    add_entry(1'b1, 7'h7F, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1);
    add_entry(1'b1, 7'h55, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b1);
    add_entry(1'b0, 7'h2A, 8'h00, 8'h00, 1'b1, 1'b0, 1'b1);
    add_entry(1'b0, 7'h0F, 8'h81, 8'h00, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, 7'h40, 8'h3C, 8'h00, 1'b0, 1'b0, 1'b0);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("tx", 1'b1, tx);
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_bit("read_rdy", 1'b0, read_rdy);
    check_bit("read_err", 1'b0, read_err);
    presented = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (!presented)
      begin
        @(posedge clk);
        #1;
        cmd_in = stim[i].cmd;
        cmd_vld = 1'b1;
      end
      while (cmd_rdy !== 1'b1)
        @(negedge clk);
      @(posedge clk);
      #1;
      check_bit("cmd_rdy", 1'b0, cmd_rdy);
      // Holding the next command here shows that it waits for cmd_rdy.
      presented = stim[i].hold_next && (i + 1 < NUM_ENTRIES);
      if (presented)
        cmd_in = stim[i + 1].cmd;
      else
        cmd_vld = 1'b0;
      if (!stim[i].cmd.f.write)
      begin
        wait (reply_req === 1'b0);
        reply_byte = stim[i].reply;
        reply_flip = stim[i].bad_par;
        reply_base = frames_seen;
        reply_req = 1'b1;
      end
      @(negedge clk);
      while (cmd_rdy !== 1'b1)
        @(negedge clk);
      #1;
      check_entry(i);
    end
    $display("Error counts: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* verilog.f */
verilog/uart_frame_pkg.sv
verilog/uart_cmd_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_tx_framer.sv
verilog/uart_rx_deframer.sv
verilog/uart_cmd_seq.sv
verilog/uart_cmd_bridge.sv
tests/tb_uart_cmd_bridge.sv

/* verilog/uart_byte_if.sv */
`timescale 1ns/1ps

interface uart_byte_if;

  // Transmit side. A byte moves on a clock edge with tx_valid and tx_ready high.
  logic                  tx_valid;
  uart_frame_pkg::byte_t tx_byte;
  logic                  tx_ready;

  // Receive side. rx_valid is a single-cycle pulse and cannot be held off.
  logic                  rx_valid;
  uart_frame_pkg::byte_t rx_byte;
  logic                  rx_parity_err;

  modport seq (
    output tx_valid, tx_byte,
    input  tx_ready,
    input  rx_valid, rx_byte, rx_parity_err
  );

  modport tx (
    input  tx_valid, tx_byte,
    output tx_ready
  );

  modport rx (
    output rx_valid, rx_byte, rx_parity_err
  );

endinterface

/* verilog/uart_cmd_bridge.sv */
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_cmd_pkg::CMD_BITS-1:0] cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  input  logic                            rx,
  output logic                            tx,
  output logic [7:0]                      read_data,
  output logic                            read_err,
  output logic                            read_rdy
);

  // Byte link shared by the sequencer and both line blocks.
  uart_byte_if u_link ();

  uart_cmd_seq #(
    .GAP_CYCLES (GAP_CYCLES)
  ) u_uart_cmd_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .link      (u_link.seq),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  uart_tx_framer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx_framer (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (u_link.tx),
    .tx    (tx)
  );

  // The receiver runs all the time; frames outside a read are dropped by the sequencer.
  uart_rx_deframer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx_deframer (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .link  (u_link.rx)
  );

endmodule

/* verilog/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // Command word as seen by the bus side.
  // Bit 15 set means a write of two frames, clear means a read.
  typedef struct packed {
    logic                  write;
    logic [6:0]            addr;
    uart_frame_pkg::byte_t data;
  } cmd_fields_t;

  // Command word as seen by the line side, high byte goes out first.
  typedef struct packed {
    uart_frame_pkg::byte_t hi;
    uart_frame_pkg::byte_t lo;
  } cmd_bytes_t;

  // The same 16 bits read either way.
  typedef union packed {
    cmd_fields_t f;
    cmd_bytes_t  b;
  } cmd_word_u;

  // Width of the command word on plain ports.
  localparam int CMD_BITS = $bits(cmd_word_u);

endpackage

/* verilog/uart_cmd_seq.sv */
`timescale 1ns/1ps

module uart_cmd_seq #(
  parameter int GAP_CYCLES = 100
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_u cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  uart_byte_if.seq                link,
  output uart_frame_pkg::byte_t   read_data,
  output logic                    read_err,
  output logic                    read_rdy
);

  localparam int GW = $clog2(GAP_CYCLES + 2);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_REPLY
  } seq_state_t;

  seq_state_t              state;
  uart_cmd_pkg::cmd_word_u cmd_q;
  logic [GW-1:0]           gap_cnt;
  logic                    lo_issued;
  logic                    cmd_take;
  logic                    tx_take;
  logic                    reply_take;

  assign cmd_rdy  = (state == S_IDLE);
  assign cmd_take = cmd_vld && cmd_rdy;

  // The low byte is offered once; afterwards the FSM only waits for the frame to finish.
  assign link.tx_valid = (state == S_SEND_HI) || ((state == S_SEND_LO) && !lo_issued);
  assign link.tx_byte  = (state == S_SEND_LO) ? cmd_q.b.lo : cmd_q.b.hi;
  assign tx_take       = link.tx_valid && link.tx_ready;

  // A reply only counts once the request frame has fully left the line.
  assign reply_take = (state == S_WAIT_REPLY) && link.tx_ready && link.rx_valid;

  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_q <= cmd_in;
    if (reply_take)
      read_data <= link.rx_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      gap_cnt   <= '0;
      lo_issued <= 1'b0;
      read_err  <= 1'b0;
      read_rdy  <= 1'b0;
    end
    else
    begin
      read_rdy <= 1'b0;
      case (state)
        S_IDLE:
          if (cmd_take)
            state <= S_SEND_HI;
        S_SEND_HI:
          if (tx_take)
          begin
            gap_cnt <= '0;
            state   <= cmd_q.f.write ? S_GAP : S_WAIT_REPLY;
          end
        S_GAP:
          // The gap is counted from the end of the first frame.
          if (link.tx_ready)
          begin
            if (gap_cnt == GW'(GAP_CYCLES))
              state <= S_SEND_LO;
            else
              gap_cnt <= gap_cnt + 1'b1;
          end
        S_SEND_LO:
          if (tx_take)
            lo_issued <= 1'b1;
          else if (lo_issued && link.tx_ready)
          begin
            lo_issued <= 1'b0;
            state     <= S_IDLE;
          end
        S_WAIT_REPLY:
          if (reply_take)
          begin
            read_err <= link.rx_parity_err;
            read_rdy <= 1'b1;
            state    <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

endmodule

/* verilog/uart_frame_pkg.sv */
package uart_frame_pkg;

  // One byte of frame payload.
  typedef logic [7:0] byte_t;

  // Bit periods in one frame: start, eight data bits, parity and stop.
  localparam int FRAME_BITS = 11;

  // Number of data bits carried by a frame.
  localparam int DATA_BITS = 8;

  // Position inside a frame, shared by the transmit and receive sides.
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_START,
    PH_DATA,
    PH_PARITY,
    PH_STOP
  } frame_phase_t;

  // Returns the bit that makes data plus parity hold an odd number of ones.
  function automatic logic odd_parity(input byte_t data);
    logic even_ones;
    even_ones = ~(^data);
    return even_ones;
  endfunction

endpackage

/* verilog/uart_rx_deframer.sv */
`timescale 1ns/1ps

module uart_rx_deframer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           rx,
  uart_byte_if.rx        link
);

  localparam int CW   = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

  uart_frame_pkg::frame_phase_t state;
  logic [CW-1:0]                clk_cnt;
  logic [2:0]                   bit_idx;
  logic                         rx_meta;
  logic                         rx_sync;
  logic                         rx_prev;
  uart_frame_pkg::byte_t        data_q;
  logic                         par_q;
  logic                         half_end;
  logic                         bit_end;
  logic                         sample_data;
  logic                         sample_par;
  logic                         frame_done;

  assign half_end    = (clk_cnt == CW'(HALF - 1));
  assign bit_end     = (clk_cnt == CW'(CLKS_PER_BIT - 1));
  assign sample_data = (state == uart_frame_pkg::PH_DATA) && bit_end;
  assign sample_par  = (state == uart_frame_pkg::PH_PARITY) && bit_end;
  assign frame_done  = (state == uart_frame_pkg::PH_STOP) && bit_end;

  // Two flops against metastability, a third one for edge detection.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Data arrives LSB first, so it shifts in from the top.
  always_ff @(posedge clk)
  begin
    if (sample_data)
      data_q <= {rx_sync, data_q[7:1]};
    if (sample_par)
      par_q <= rx_sync;
    if (frame_done)
      link.rx_byte <= data_q;
  end

  // After the start check the counter is aligned to mid-bit, so every full
  // period that follows lands in the middle of the next bit.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state              <= uart_frame_pkg::PH_IDLE;
      clk_cnt            <= '0;
      bit_idx            <= '0;
      link.rx_valid      <= 1'b0;
      link.rx_parity_err <= 1'b0;
    end
    else
    begin
      link.rx_valid <= 1'b0;
      case (state)
        uart_frame_pkg::PH_IDLE:
        begin
          clk_cnt <= '0;
          if (rx_prev && !rx_sync)
            state <= uart_frame_pkg::PH_START;
        end
        uart_frame_pkg::PH_START:
          if (half_end)
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? uart_frame_pkg::PH_IDLE : uart_frame_pkg::PH_DATA;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        uart_frame_pkg::PH_DATA:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
          begin
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'(uart_frame_pkg::DATA_BITS - 1))
              state <= uart_frame_pkg::PH_PARITY;
          end
        end
        uart_frame_pkg::PH_PARITY:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
            state <= uart_frame_pkg::PH_STOP;
        end
        default:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
          begin
            state              <= uart_frame_pkg::PH_IDLE;
            link.rx_valid      <= 1'b1;
            link.rx_parity_err <= (par_q != uart_frame_pkg::odd_parity(data_q));
          end
        end
      endcase
    end
  end

endmodule

/* verilog/uart_tx_framer.sv */
`timescale 1ns/1ps

module uart_tx_framer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic           clk,
  input  logic           rst_n,
  uart_byte_if.tx        link,
  output logic           tx
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  uart_frame_pkg::frame_phase_t state;
  logic [CW-1:0]                clk_cnt;
  logic [2:0]                   bit_idx;
  uart_frame_pkg::byte_t        data_q;
  logic                         bit_end;
  logic                         take;

  assign bit_end       = (clk_cnt == CW'(CLKS_PER_BIT - 1));
  assign link.tx_ready = (state == uart_frame_pkg::PH_IDLE);
  assign take          = link.tx_valid && link.tx_ready;

  always_ff @(posedge clk)
  begin
    if (take)
      data_q <= link.tx_byte;
  end

  // The line level is registered, so each bit changes on the edge that ends the last one.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= uart_frame_pkg::PH_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else
    begin
      if (state == uart_frame_pkg::PH_IDLE)
        clk_cnt <= '0;
      else
        clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;

      case (state)
        uart_frame_pkg::PH_IDLE:
          if (take)
          begin
            state <= uart_frame_pkg::PH_START;
            tx    <= 1'b0;
          end
        uart_frame_pkg::PH_START:
          if (bit_end)
          begin
            state   <= uart_frame_pkg::PH_DATA;
            bit_idx <= '0;
            tx      <= data_q[0];
          end
        uart_frame_pkg::PH_DATA:
          if (bit_end)
          begin
            if (bit_idx == 3'(uart_frame_pkg::DATA_BITS - 1))
            begin
              state <= uart_frame_pkg::PH_PARITY;
              tx    <= uart_frame_pkg::odd_parity(data_q);
            end
            else
            begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= data_q[3'(bit_idx + 3'd1)];
            end
          end
        uart_frame_pkg::PH_PARITY:
          if (bit_end)
          begin
            state <= uart_frame_pkg::PH_STOP;
            tx    <= 1'b1;
          end
        default:
          if (bit_end)
            state <= uart_frame_pkg::PH_IDLE;
      endcase
    end
  end

endmodule
